// ==== vlog.f ====
hw/swu_pkg.sv
hw/swu_flow_if.sv
hw/swu_line_buffer.sv
hw/swu_line_writer.sv
hw/swu_window_seq.sv
hw/swu_out_stage.sv
hw/swu_top.sv
dv/tb_swu.sv

// ==== dv/tb_swu.sv ====
`timescale 1ns/1ps

module tb_swu;

   localparam int K           = 3;
   localparam int S           = 2;
   localparam int W           = 7;
   localparam int H           = 7;
   localparam int CH          = 4;
   localparam int SIMD        = 2;
   localparam int PREC        = 8;
   localparam int DATA_W      = SIMD * PREC;
   localparam int EFF_CH      = CH / SIMD;
   localparam int ROW_WORDS   = W * EFF_CH;
   localparam int BUF_WORDS   = (K + S - 1) * ROW_WORDS;
   localparam int FRAME_WORDS = H * ROW_WORDS;
   localparam int OW          = (W - K) / S + 1;
   localparam int OH          = (H - K) / S + 1;
   localparam int OUT_WORDS   = OH * OW * K * K * EFF_CH;

   logic              clk;
   logic              resetn;
   logic [DATA_W-1:0] s_tdata_i;
   logic              s_tvalid_i;
   logic              s_tready_o;
   logic [DATA_W-1:0] m_tdata_o;
   logic              m_tvalid_o;
   logic              m_tready_i;

   int                errors;
   int                checks;
   int                tests_run;
   int                tests_failed;
   logic [DATA_W-1:0] exp_q [$];

   swu_top #(
      .K(K), .S(S), .W(W), .H(H), .CH(CH), .SIMD(SIMD), .PREC(PREC)
   ) dut0 (
      .clk        (clk),
      .resetn     (resetn),
      .s_tdata_i  (s_tdata_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .m_tdata_o  (m_tdata_o),
      .m_tvalid_o (m_tvalid_o),
      .m_tready_i (m_tready_i)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // input word n carries lanes 2n and 2n+1, lane 0 in the low byte
   function automatic logic [DATA_W-1:0] make_word(input int n);
      logic [7:0] lo;
      logic [7:0] hi;
      lo = 8'((n * 2) % 256);
      hi = 8'((n * 2 + 1) % 256);
      return {hi, lo};
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      resetn     = 1'b0;
      s_tvalid_i = 1'b0;
      m_tready_i = 1'b0;
      repeat (4) @(posedge clk);
      #1 resetn = 1'b1;
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      if (errors != err0) begin
         tests_failed++;
      end
      $display("test %s: %s (%0d errors)", name, (errors == err0) ? "ok" : "failed",
               errors - err0);
   endtask

   // window order: kernel row, kernel column, channel word
   task automatic build_expected(input int frames);
      int idx;
      exp_q.delete();
      for (int f = 0; f < frames; f++)
         for (int oy = 0; oy < OH; oy++)
            for (int ox = 0; ox < OW; ox++)
               for (int kh = 0; kh < K; kh++)
                  for (int kw = 0; kw < K; kw++)
                     for (int c = 0; c < EFF_CH; c++) begin
                        idx = ((oy * S + kh) * W + ox * S + kw) * EFF_CH + c;
                        exp_q.push_back(make_word(idx));
                     end
   endtask

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////

   task automatic test_after_reset();
      int err0;
      err0 = errors;
      apply_reset();
      @(negedge clk);
      check_eq("m_tvalid_o", m_tvalid_o, 1'b0);
      check_eq("s_tready_o", s_tready_o, 1'b1);
      finish_test("after_reset", err0);
   endtask

   // ready_mode 0 always ready, 1 random, 2 low for hold cycles then high
   task automatic stream_frames(input string name, input int frames, input int ready_mode,
                                input bit gaps, input int hold);
      int                err0;
      int                in_idx;
      int                out_idx;
      int                cycles;
      int                limit;
      int                total_in;
      int                total_out;
      bit                hs_in;
      bit                stalled;
      logic [DATA_W-1:0] held;
      err0      = errors;
      total_in  = frames * FRAME_WORDS;
      total_out = frames * OUT_WORDS;
      limit     = frames * 4000 + hold;
      in_idx    = 0;
      out_idx   = 0;
      cycles    = 0;
      hs_in     = 1'b0;
      stalled   = 1'b0;
      held      = '0;
      build_expected(frames);
      apply_reset();
      while ((in_idx < total_in || out_idx < total_out) && cycles < limit) begin
         @(posedge clk);
         #1;
         // a valid word stays put until it is taken
         if (!s_tvalid_i || hs_in) begin
            s_tvalid_i = (in_idx < total_in) && (!gaps || ($urandom % 3) != 0);
            s_tdata_i  = make_word(in_idx % FRAME_WORDS);
         end
         case (ready_mode)
            0:       m_tready_i = 1'b1;
            1:       m_tready_i = 1'($urandom % 2);
            default: m_tready_i = (cycles >= hold);
         endcase
         @(negedge clk);
         hs_in = s_tvalid_i && s_tready_o;
         if (hs_in) begin
            in_idx++;
         end
         if (stalled) begin
            check_eq("m_tvalid_o held", m_tvalid_o, 1'b1);
            check_eq("m_tdata_o held", m_tdata_o, held);
         end
         if (m_tvalid_o && m_tready_i) begin
            if (out_idx < total_out) begin
               check_eq($sformatf("m_tdata_o[%0d]", out_idx), m_tdata_o, exp_q[out_idx]);
            end else begin
               $display("error at %0t ns: output word beyond the expected %0d", $time,
                        total_out);
               errors++;
            end
            out_idx++;
         end
         if (ready_mode == 2 && cycles == hold - 1) begin
            check_eq("accepted words while output stalled", in_idx, BUF_WORDS);
         end
         stalled = m_tvalid_o && !m_tready_i;
         held    = m_tdata_o;
         cycles++;
      end
      if (in_idx < total_in || out_idx < total_out) begin
         $display("error: %s timed out after %0d cycles with %0d words in and %0d words out",
                  name, cycles, in_idx, out_idx);
         errors++;
      end
      // nothing more may come out once the frames are done
      repeat (8) begin
         @(posedge clk);
         #1;
         s_tvalid_i = 1'b0;
         m_tready_i = 1'b1;
         @(negedge clk);
         check_eq("m_tvalid_o after last word", m_tvalid_o, 1'b0);
      end
      finish_test(name, err0);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      clk          = 1'b0;
      resetn       = 1'b0;
      s_tdata_i    = '0;
      s_tvalid_i   = 1'b0;
      m_tready_i   = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(71));
      test_after_reset();
      stream_frames("full_window_order", 1, 0, 1'b0, 0);
      stream_frames("output_backpressure", 1, 1, 1'b0, 0);
      stream_frames("input_limit", 1, 2, 1'b0, 300);
      stream_frames("back_to_back_frames", 2, 0, 1'b1, 0);
      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
               checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== hw/swu_top.sv ====
`timescale 1ns/1ps

module swu_top #(
   parameter int K    = swu_pkg::DEF_K,
   parameter int S    = swu_pkg::DEF_S,
   parameter int W    = swu_pkg::DEF_W,
   parameter int H    = swu_pkg::DEF_H,
   parameter int CH   = swu_pkg::DEF_CH,
   parameter int SIMD = swu_pkg::DEF_SIMD,
   parameter int PREC = swu_pkg::DEF_PREC
) (
   input  logic                 clk,
   input  logic                 resetn,
   input  logic [SIMD*PREC-1:0] s_tdata_i,
   input  logic                 s_tvalid_i,
   output logic                 s_tready_o,
   output logic [SIMD*PREC-1:0] m_tdata_o,
   output logic                 m_tvalid_o,
   input  logic                 m_tready_i
);

   localparam int BUF_WORDS = (K + S - 1) * W * (CH / SIMD);
   localparam int ADDR_W    = $clog2(BUF_WORDS);
   localparam int DATA_W    = SIMD * PREC;

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0] rd_data;
   logic              slot_free;

   swu_flow_if flow ();

   ////////////////////////////////////////////////////////////
   // input side, buffer, sequencer, output side
   ////////////////////////////////////////////////////////////

   swu_line_writer #(
      .K(K), .S(S), .W(W), .H(H), .CH(CH), .SIMD(SIMD), .PREC(PREC)
   ) u_writer (
      .clk_i      (clk),
      .resetn_i   (resetn),
      .flow_o     (flow.writer),
      .s_tdata_i  (s_tdata_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .wr_en_o    (wr_en),
      .wr_addr_o  (wr_addr),
      .wr_data_o  (wr_data)
   );

   swu_line_buffer #(
      .K(K), .S(S), .W(W), .CH(CH), .SIMD(SIMD), .PREC(PREC)
   ) u_buffer (
      .clk_i     (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   swu_window_seq #(
      .K(K), .S(S), .W(W), .H(H), .CH(CH), .SIMD(SIMD)
   ) u_seq (
      .clk_i       (clk),
      .resetn_i    (resetn),
      .flow_i      (flow.reader),
      .slot_free_i (slot_free),
      .rd_en_o     (rd_en),
      .rd_addr_o   (rd_addr)
   );

   swu_out_stage #(
      .SIMD(SIMD), .PREC(PREC)
   ) u_out (
      .clk_i       (clk),
      .resetn_i    (resetn),
      .rd_en_i     (rd_en),
      .rd_data_i   (rd_data),
      .slot_free_o (slot_free),
      .m_tdata_o   (m_tdata_o),
      .m_tvalid_o  (m_tvalid_o),
      .m_tready_i  (m_tready_i)
   );

endmodule

// ==== hw/swu_out_stage.sv ====
`timescale 1ns/1ps

module swu_out_stage #(
   parameter int SIMD = 3,
   parameter int PREC = 8,
   localparam int DATA_W = SIMD * PREC
) (
   input  logic              clk_i,
   input  logic              resetn_i,
   input  logic              rd_en_i,
   input  logic [DATA_W-1:0] rd_data_i,
   output logic              slot_free_o,
   output logic [DATA_W-1:0] m_tdata_o,
   output logic              m_tvalid_o,
   input  logic              m_tready_i
);

   logic              rd_en_q;
   logic [DATA_W-1:0] q_data [2];
   logic              wr_ptr_q;
   logic              rd_ptr_q;
   logic [1:0]        count_q;
   logic              push;
   logic              pop;

   // buffer data is valid one cycle after the read
   assign push = rd_en_q;
   assign pop  = m_tvalid_o && m_tready_i;

   // queued words plus the one still coming out of the buffer
   assign slot_free_o = (count_q + {1'b0, rd_en_q}) < 2'd2;

   assign m_tvalid_o = (count_q != 2'd0);
   assign m_tdata_o  = q_data[rd_ptr_q];

   ////////////////////////////////////////////////////////////
   // two-entry queue
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!resetn_i) begin
         rd_en_q  <= 1'b0;
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end else begin
         rd_en_q <= rd_en_i;
         if (push) begin
            wr_ptr_q <= !wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= !rd_ptr_q;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         q_data[wr_ptr_q] <= rd_data_i;
      end
   end

endmodule

// ==== hw/swu_window_seq.sv ====
`timescale 1ns/1ps

module swu_window_seq #(
   parameter int K    = 3,
   parameter int S    = 2,
   parameter int W    = 224,
   parameter int H    = 224,
   parameter int CH   = 3,
   parameter int SIMD = 3,
   localparam int EFF_CH    = CH / SIMD,
   localparam int ROW_WORDS = W * EFF_CH,
   localparam int BUF_WORDS = (K + S - 1) * ROW_WORDS,
   localparam int ADDR_W    = $clog2(BUF_WORDS)
) (
   input  logic              clk_i,
   input  logic              resetn_i,
   swu_flow_if.reader        flow_i,
   input  logic              slot_free_i,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o
);
   import swu_pkg::*;

   localparam int OW = (W - K) / S + 1;
   localparam int OH = (H - K) / S + 1;

   // index jump from the last word of a kernel row to the next kernel row
   localparam int STEP_KH = ROW_WORDS - K * EFF_CH + 1;
   // last word of a window to the first word of the next window in the row
   localparam int STEP_OX = S * EFF_CH - (K - 1) * ROW_WORDS - K * EFF_CH + 1;
   // last word of an output row to the first window of the next one
   localparam int STEP_OY = (S - K + 1) * ROW_WORDS - ((OW - 1) * S + K) * EFF_CH + 1;

   // same jumps folded into 0..BUF_WORDS-1 for the circular address
   localparam int MOD_KH = ((STEP_KH % BUF_WORDS) + BUF_WORDS) % BUF_WORDS;
   localparam int MOD_OX = ((STEP_OX % BUF_WORDS) + BUF_WORDS) % BUF_WORDS;
   localparam int MOD_OY = ((STEP_OY % BUF_WORDS) + BUF_WORDS) % BUF_WORDS;

   logic [$clog2(EFF_CH+1)-1:0] c_q;
   logic [$clog2(K+1)-1:0]      kw_q;
   logic [$clog2(K+1)-1:0]      kh_q;
   logic [$clog2(OW+1)-1:0]     ox_q;
   logic [$clog2(OH+1)-1:0]     oy_q;
   logic [CNT_W-1:0]            tgt_q;
   logic [CNT_W-1:0]            need_base_q;
   logic [ADDR_W-1:0]           addr_q;
   logic                        wait_end_q;

   logic              last_c;
   logic              last_kw;
   logic              last_kh;
   logic              last_ox;
   logic              last_oy;
   logic              issue;
   logic              frame_done;
   logic [CNT_W-1:0]  tgt_step;
   logic [ADDR_W:0]   addr_step;
   logic [ADDR_W:0]   addr_sum;
   logic [ADDR_W:0]   addr_wrap;
   logic [ADDR_W-1:0] addr_next;

   assign last_c  = (c_q == EFF_CH - 1);
   assign last_kw = (kw_q == K - 1);
   assign last_kh = (kh_q == K - 1);
   assign last_ox = (ox_q == OW - 1);
   assign last_oy = (oy_q == OH - 1);

   ////////////////////////////////////////////////////////////
   // read issue and frame end
   ////////////////////////////////////////////////////////////

   // target word must already be written and the output must have room
   assign issue      = !wait_end_q && slot_free_i && (tgt_q < flow_i.wr_count);
   assign frame_done = wait_end_q && flow_i.frame_full;

   assign rd_en_o   = issue;
   assign rd_addr_o = addr_q;

   assign flow_i.need_base  = need_base_q;
   assign flow_i.frame_done = frame_done;

   ////////////////////////////////////////////////////////////
   // next target
   ////////////////////////////////////////////////////////////

   // channel words and kernel columns are contiguous in the buffer
   always_comb begin
      if (!last_c || !last_kw) begin
         tgt_step  = CNT_W'(1);
         addr_step = (ADDR_W+1)'(1);
      end else if (!last_kh) begin
         tgt_step  = CNT_W'(STEP_KH);
         addr_step = (ADDR_W+1)'(MOD_KH);
      end else if (!last_ox) begin
         tgt_step  = CNT_W'(STEP_OX);
         addr_step = (ADDR_W+1)'(MOD_OX);
      end else begin
         tgt_step  = CNT_W'(STEP_OY);
         addr_step = (ADDR_W+1)'(MOD_OY);
      end
   end

   assign addr_sum  = {1'b0, addr_q} + addr_step;
   assign addr_wrap = addr_sum - (ADDR_W+1)'(BUF_WORDS);
   assign addr_next = (addr_sum >= (ADDR_W+1)'(BUF_WORDS)) ? addr_wrap[ADDR_W-1:0]
                                                           : addr_sum[ADDR_W-1:0];

   ////////////////////////////////////////////////////////////
   // position counters
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!resetn_i || frame_done) begin
         c_q         <= '0;
         kw_q        <= '0;
         kh_q        <= '0;
         ox_q        <= '0;
         oy_q        <= '0;
         tgt_q       <= '0;
         need_base_q <= '0;
         addr_q      <= '0;
         wait_end_q  <= 1'b0;
      end else if (issue) begin
         if (last_c && last_kw && last_kh && last_ox && last_oy) begin
            // last window word is out, hold until the input frame drains
            wait_end_q <= 1'b1;
         end else begin
            tgt_q  <= tgt_q + tgt_step;
            addr_q <= addr_next;
            if (!last_c) begin
               c_q <= c_q + 1'b1;
            end else begin
               c_q <= '0;
               if (!last_kw) begin
                  kw_q <= kw_q + 1'b1;
               end else begin
                  kw_q <= '0;
                  if (!last_kh) begin
                     kh_q <= kh_q + 1'b1;
                  end else begin
                     kh_q <= '0;
                     if (!last_ox) begin
                        ox_q <= ox_q + 1'b1;
                     end else begin
                        ox_q        <= '0;
                        oy_q        <= oy_q + 1'b1;
                        // rows above the new window are free for the writer
                        need_base_q <= need_base_q + CNT_W'(S * ROW_WORDS);
                     end
                  end
               end
            end
         end
      end
   end

endmodule

// ==== hw/swu_line_writer.sv ====
`timescale 1ns/1ps

module swu_line_writer #(
   parameter int K    = 3,
   parameter int S    = 2,
   parameter int W    = 224,
   parameter int H    = 224,
   parameter int CH   = 3,
   parameter int SIMD = 3,
   parameter int PREC = 8,
   localparam int EFF_CH    = CH / SIMD,
   localparam int ROW_WORDS = W * EFF_CH,
   localparam int BUF_WORDS = (K + S - 1) * ROW_WORDS,
   localparam int ADDR_W    = $clog2(BUF_WORDS)
) (
   input  logic                   clk_i,
   input  logic                   resetn_i,
   swu_flow_if.writer             flow_o,
   input  logic [SIMD*PREC-1:0]   s_tdata_i,
   input  logic                   s_tvalid_i,
   output logic                   s_tready_o,
   output logic                   wr_en_o,
   output logic [ADDR_W-1:0]      wr_addr_o,
   output logic [SIMD*PREC-1:0]   wr_data_o
);
   import swu_pkg::*;

   localparam int FRAME_WORDS = H * ROW_WORDS;

   logic [CNT_W-1:0]  wr_count_q;
   logic [ADDR_W-1:0] wr_addr_q;
   logic [CNT_W:0]    accept_limit;
   logic              frame_full;
   logic              s_hs;

   ////////////////////////////////////////////////////////////
   // free-space rule
   ////////////////////////////////////////////////////////////

   // word n may land only once the slot it reuses is behind need_base
   assign accept_limit = {1'b0, flow_o.need_base} + (CNT_W+1)'(BUF_WORDS);
   assign frame_full   = (wr_count_q == CNT_W'(FRAME_WORDS));
   assign s_tready_o   = !frame_full && ({1'b0, wr_count_q} < accept_limit);
   assign s_hs         = s_tvalid_i && s_tready_o;

   assign flow_o.wr_count   = wr_count_q;
   assign flow_o.frame_full = frame_full;

   ////////////////////////////////////////////////////////////
   // write side of the line buffer
   ////////////////////////////////////////////////////////////

   assign wr_en_o   = s_hs;
   assign wr_addr_o = wr_addr_q;
   assign wr_data_o = s_tdata_i;

   // frame word count and circular write pointer
   always_ff @(posedge clk_i) begin
      if (!resetn_i || flow_o.frame_done) begin
         wr_count_q <= '0;
         wr_addr_q  <= '0;
      end else if (s_hs) begin
         wr_count_q <= wr_count_q + 1'b1;
         if (wr_addr_q == ADDR_W'(BUF_WORDS - 1)) begin
            wr_addr_q <= '0;
         end else begin
            wr_addr_q <= wr_addr_q + 1'b1;
         end
      end
   end

endmodule

// ==== hw/swu_line_buffer.sv ====
`timescale 1ns/1ps

module swu_line_buffer #(
   parameter int K    = 3,
   parameter int S    = 2,
   parameter int W    = 224,
   parameter int CH   = 3,
   parameter int SIMD = 3,
   parameter int PREC = 8,
   localparam int EFF_CH    = CH / SIMD,
   localparam int BUF_WORDS = (K + S - 1) * W * EFF_CH,
   localparam int ADDR_W    = $clog2(BUF_WORDS),
   localparam int DATA_W    = SIMD * PREC
) (
   input  logic              clk_i,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0] rd_data_o
);

   // K+S-1 image rows, one word per entry
   logic [DATA_W-1:0] mem [BUF_WORDS];

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read register holds its word until the next read
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== hw/swu_flow_if.sv ====
`timescale 1ns/1ps

interface swu_flow_if;
   import swu_pkg::*;

   // words accepted from the input stream in this frame
   logic [CNT_W-1:0] wr_count;

   // whole frame has been written
   logic             frame_full;

   // first word of the oldest row the sequencer still reads
   logic [CNT_W-1:0] need_base;

   // single-cycle restart of both sides
   logic             frame_done;

   // input side
   modport writer (
      output wr_count,
      output frame_full,
      input  need_base,
      input  frame_done
   );

   // window sequencer side
   modport reader (
      input  wr_count,
      input  frame_full,
      output need_base,
      output frame_done
   );

endinterface

// ==== hw/swu_pkg.sv ====
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // counters
   ////////////////////////////////////////////////////////////

   // word counters that run across a whole frame
   // 24 bits covers a 224x224 image with many channel words per pixel
   localparam int CNT_W = 24;

   ////////////////////////////////////////////////////////////
   // default geometry
   ////////////////////////////////////////////////////////////

   // kernel size and stride, same in both directions
   localparam int DEF_K = 3;
   localparam int DEF_S = 2;

   // input image size in pixels
   localparam int DEF_W = 224;
   localparam int DEF_H = 224;

   // channels per pixel and channels packed into one stream word
   localparam int DEF_CH   = 3;
   localparam int DEF_SIMD = 3;

   // bits per channel value
   localparam int DEF_PREC = 8;

endpackage
